// File: rtl/st_mem_defs.svh
/* st memory path constants */

`ifndef ST_MEM_DEFS_SVH
`define ST_MEM_DEFS_SVH

////////////////////
// bus widths
////////////////////

// word address, byte address bits 23..1
`define ST_ADDR_W 23
`define ST_DATA_W 16

// upload buffer depth, also the producer's starting credits
`define UPLOAD_FIFO_DEPTH 4

////////////////////
// 8 mhz bus slots
////////////////////

`define SLOT_PRECYCLE 2'd0
`define SLOT_CPU      2'd1
`define SLOT_VIDEO    2'd2

// first byte address per upload index
`define UPLOAD_BASE_TOS256 24'hE00000
`define UPLOAD_BASE_TOS192 24'hFC0000
`define UPLOAD_BASE_CART   24'hFA0000
`define UPLOAD_BASE_CLEAR  24'h000000

`endif

// File: rtl/st_mem_pkg.sv
/* st memory path types */

`include "st_mem_defs.svh"

package st_mem_pkg;

	// rom view of a word address
	// region is byte address bits 23..18
	typedef struct packed {
		logic [5:0]  region;
		logic [16:0] offset;
	} st_rom_addr_t;

	// one word address, read flat or as region/offset
	typedef union packed {
		logic [`ST_ADDR_W-1:0] word;
		st_rom_addr_t          rom;
	} st_addr_u;

	typedef enum logic [2:0] {
		MEM512K = 3'd0,
		MEM1M   = 3'd1,
		MEM2M   = 3'd2,
		MEM4M   = 3'd3,
		MEM8M   = 3'd4,
		MEM14M  = 3'd5
	} mem_size_e;

	// addressed upload word, producer to consumer
	typedef struct packed {
		st_addr_u              addr;
		logic [`ST_DATA_W-1:0] data;
	} upload_word_t;

	// host side upload strobe and level
	typedef struct packed {
		logic                  download;
		logic                  wr;
		logic [3:0]            index;
		logic [`ST_DATA_W-1:0] data;
	} host_upload_t;

	// chipset side cpu ram/rom access
	typedef struct packed {
		logic                  ras_n;
		logic                  rom2_n;
		logic                  we;
		logic                  uds;
		logic                  lds;
		st_addr_u              addr;
		logic [`ST_DATA_W-1:0] wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic                  req;
		logic                  we;
		logic                  uds;
		logic                  lds;
		st_addr_u              addr;
		logic [`ST_DATA_W-1:0] wdata;
	} sdram_req_t;

endpackage

// File: rtl/upload_sequencer.sv
/* upload word producer */

`include "st_mem_defs.svh"

module upload_sequencer (
	input  logic                      clk_32,
	input  logic                      xsint,
	input  st_mem_pkg::host_upload_t  upload_i,
	input  logic                      credit_i,
	output logic                      push_o,
	output st_mem_pkg::upload_word_t  word_o,
	output logic                      upload_busy_o,
	output logic                      tos192k_o,
	output logic                      overrun_o
);

	localparam int CREDIT_W = $clog2(`UPLOAD_FIFO_DEPTH + 1);
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`UPLOAD_FIFO_DEPTH);

	logic                    download_d;
	logic [`ST_ADDR_W:0]     base_byte;
	st_mem_pkg::st_addr_u    addr_q;
	st_mem_pkg::st_addr_u    addr_cur;
	st_mem_pkg::st_addr_u    addr_nxt;
	logic [CREDIT_W-1:0]     credits;
	logic                    strobe;
	logic                    accept;

	////////////////////
	// address
	////////////////////

	// base byte address by upload index
	always_comb begin
		case (upload_i.index)
			4'd0: base_byte = `UPLOAD_BASE_TOS256;
			4'd1: base_byte = `UPLOAD_BASE_TOS192;
			4'd2: base_byte = `UPLOAD_BASE_CART;
			default: base_byte = `UPLOAD_BASE_CLEAR;
		endcase
	end

	// start of download loads base minus one word
	// clear base wraps to all ones
	// so the first write lands on 0
	always_comb begin
		addr_cur = addr_q;
		if (upload_i.download & ~download_d)
			addr_cur.word = base_byte[`ST_ADDR_W:1] - 1'b1;
		addr_nxt.word = addr_cur.word + 1'b1;
	end

	// a strobe needs a free buffer slot
	assign strobe = upload_i.wr & upload_i.download;
	assign accept = strobe & (credits != '0);

	// busy until every pushed word has come back as a credit
	assign upload_busy_o = upload_i.download | (credits != CREDIT_MAX);

	////////////////////
	// control
	////////////////////

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			download_d <= 1'b0;
			addr_q     <= '0;
			credits    <= CREDIT_MAX;
			push_o     <= 1'b0;
			overrun_o  <= 1'b0;
			tos192k_o  <= 1'b0;
		end else begin
			download_d <= upload_i.download;
			addr_q     <= accept ? addr_nxt : addr_cur;
			push_o     <= accept;
			// one credit back per pop and one spent per push
			credits    <= credits + CREDIT_W'(credit_i) - CREDIT_W'(accept);
			// sticky on a lost host strobe
			if (strobe & ~accept)
				overrun_o <= 1'b1;
			// last region touched picks the rom image
			if (accept) begin
				if (addr_nxt.rom.region == 6'h3F)
					tos192k_o <= 1'b1;
				else if (addr_nxt.word[`ST_ADDR_W-1 -: 4] == 4'hE)
					tos192k_o <= 1'b0;
			end
		end
	end

	// word to buffer with bytes swapped
	always_ff @(posedge clk_32) begin
		if (accept) begin
			word_o.addr <= addr_nxt;
			word_o.data <= {upload_i.data[`ST_DATA_W/2-1:0],
				upload_i.data[`ST_DATA_W-1:`ST_DATA_W/2]};
		end
	end

endmodule

// File: rtl/upload_fifo.sv
/* upload word buffer */

`include "st_mem_defs.svh"

module upload_fifo (
	input  logic                      clk_32,
	input  logic                      xsint,
	input  logic                      push_i,
	input  st_mem_pkg::upload_word_t  word_i,
	input  logic                      pop_i,
	output st_mem_pkg::upload_word_t  head_o,
	output logic                      not_empty_o,
	output logic                      credit_o
);

	localparam int PTR_W = (`UPLOAD_FIFO_DEPTH > 1) ? $clog2(`UPLOAD_FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(`UPLOAD_FIFO_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(`UPLOAD_FIFO_DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL = CNT_W'(`UPLOAD_FIFO_DEPTH);

	st_mem_pkg::upload_word_t mem [`UPLOAD_FIFO_DEPTH];
	logic [PTR_W-1:0]         wr_ptr;
	logic [PTR_W-1:0]         rd_ptr;
	logic [CNT_W-1:0]         count;
	logic                     do_push;
	logic                     do_pop;

	// producer credits keep it from pushing into a full buffer
	assign do_push = push_i & (count != FULL);
	assign do_pop  = pop_i & (count != '0);

	assign head_o      = mem[rd_ptr];
	assign not_empty_o = (count != '0);

	////////////////////
	// pointers
	////////////////////

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			count    <= count + CNT_W'(do_push) - CNT_W'(do_pop);
			// credit goes back the cycle after a pop
			credit_o <= do_pop;
		end
	end

	// storage
	always_ff @(posedge clk_32) begin
		if (do_push)
			mem[wr_ptr] <= word_i;
	end

endmodule

// File: rtl/st_addr_decode.sv
/* cpu address decoder */

module st_addr_decode (
	input  st_mem_pkg::cpu_bus_t   cpu_i,
	input  st_mem_pkg::mem_size_e  mem_size_i,
	input  logic                   tos192k_i,
	output logic                   ram_en_o,
	output st_mem_pkg::st_addr_u   rom_addr_o
);

	////////////////////
	// ram range
	////////////////////

	// top word address bits against the fitted size
	always_comb begin
		case (mem_size_i)
			st_mem_pkg::MEM512K: ram_en_o = (cpu_i.addr.word[22:18] == 5'b00000);
			st_mem_pkg::MEM1M:   ram_en_o = (cpu_i.addr.word[22:19] == 4'b0000);
			st_mem_pkg::MEM2M:   ram_en_o = (cpu_i.addr.word[22:20] == 3'b000);
			st_mem_pkg::MEM4M:   ram_en_o = (cpu_i.addr.word[22:21] == 2'b00);
			st_mem_pkg::MEM8M:   ram_en_o = ~cpu_i.addr.word[22];
			// 14M, all below $e00000
			st_mem_pkg::MEM14M:  ram_en_o = (cpu_i.addr.word[22:20] != 3'b111);
			default:             ram_en_o = 1'b0;
		endcase
	end

	////////////////////
	// rom window
	////////////////////

	// tos window goes to $e00000 or $fc0000
	// offset is kept as is
	always_comb begin
		rom_addr_o = cpu_i.addr;
		if (!cpu_i.rom2_n)
			rom_addr_o.rom.region = tos192k_i ? 6'h3F : 6'h38;
	end

endmodule

// File: rtl/ram_port_mux.sv
/* sdram port slot mux */

`include "st_mem_defs.svh"

module ram_port_mux (
	input  logic                      clk_32,
	input  logic                      xsint,
	input  st_mem_pkg::cpu_bus_t      cpu_i,
	input  logic                      ram_en_i,
	input  logic                      upload_busy_i,
	input  st_mem_pkg::upload_word_t  head_i,
	input  logic                      not_empty_i,
	output logic                      pop_o,
	output st_mem_pkg::sdram_req_t    sdram_o
);

	logic [1:0]               phase_q;
	logic [1:0]               slot_q;
	logic [1:0]               slot_nxt;
	logic                     mhz8_en;
	logic                     en_nxt;
	logic                     ras_n_d;
	logic                     ras_fall;
	logic                     wr_pending;
	logic                     wr_go;
	logic                     cpu_slot_busy;
	logic                     cpu_go;
	st_mem_pkg::upload_word_t held_q;

	////////////////////
	// bus schedule
	////////////////////

	// clk_32 / 4, phase 0 is the first clock of a slot
	assign mhz8_en = (phase_q == 2'd0);
	assign en_nxt  = (phase_q == 2'd3);

	// slot seen by a request issued next clock
	assign slot_nxt = en_nxt ? slot_q + 2'd1 : slot_q;

	// upload word taken at start of precycle slot
	assign pop_o = mhz8_en & (slot_q == `SLOT_PRECYCLE) & not_empty_i;

	// write lands on first clock of the cpu slot, 4 clocks after the pop
	assign wr_go = wr_pending & en_nxt & (slot_nxt == `SLOT_CPU);

	////////////////////
	// cpu access
	////////////////////

	assign ras_fall = ras_n_d & ~cpu_i.ras_n;

	// cpu slot is owned by the upload while it runs
	assign cpu_slot_busy = upload_busy_i & (slot_nxt == `SLOT_CPU);

	// word address 0 never goes out
	assign cpu_go = ras_fall & ram_en_i & (|cpu_i.addr.word) & ~cpu_slot_busy & ~wr_go;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			phase_q    <= 2'd0;
			slot_q     <= `SLOT_PRECYCLE;
			ras_n_d    <= 1'b1;
			wr_pending <= 1'b0;
			sdram_o    <= '0;
		end else begin
			phase_q <= phase_q + 2'd1;
			slot_q  <= slot_nxt;
			ras_n_d <= cpu_i.ras_n;

			if (pop_o)
				wr_pending <= 1'b1;
			else if (wr_go)
				wr_pending <= 1'b0;

			// one clock request, upload write first
			sdram_o.req <= wr_go | cpu_go;
			if (wr_go) begin
				// upload always writes the full word
				sdram_o.we    <= 1'b1;
				sdram_o.uds   <= 1'b1;
				sdram_o.lds   <= 1'b1;
				sdram_o.addr  <= held_q.addr;
				sdram_o.wdata <= held_q.data;
			end else begin
				sdram_o.we    <= cpu_i.we;
				sdram_o.uds   <= cpu_i.uds;
				sdram_o.lds   <= cpu_i.lds;
				sdram_o.addr  <= cpu_i.addr;
				sdram_o.wdata <= cpu_i.wdata;
			end
		end
	end

	// popped word waits here for the cpu slot
	always_ff @(posedge clk_32) begin
		if (pop_o)
			held_q <= head_i;
	end

endmodule

// File: rtl/st_mem_top.sv
/* st memory path top */

module st_mem_top (
	input  logic                      clk_32,
	input  logic                      xsint,
	input  st_mem_pkg::host_upload_t  upload_i,
	input  st_mem_pkg::cpu_bus_t      cpu_i,
	input  st_mem_pkg::mem_size_e     mem_size_i,
	output st_mem_pkg::sdram_req_t    sdram_o,
	output st_mem_pkg::st_addr_u      rom_addr_o,
	output logic                      overrun_o
);

	// producer to buffer
	logic                     push;
	st_mem_pkg::upload_word_t push_word;
	logic                     credit;

	// buffer to consumer
	st_mem_pkg::upload_word_t head_word;
	logic                     not_empty;
	logic                     pop;

	logic                     upload_busy;
	logic                     tos192k;
	logic                     ram_en;

	upload_sequencer u_upload_sequencer (
		.clk_32        (clk_32),
		.xsint         (xsint),
		.upload_i      (upload_i),
		.credit_i      (credit),
		.push_o        (push),
		.word_o        (push_word),
		.upload_busy_o (upload_busy),
		.tos192k_o     (tos192k),
		.overrun_o     (overrun_o)
	);

	upload_fifo u_upload_fifo (
		.clk_32      (clk_32),
		.xsint       (xsint),
		.push_i      (push),
		.word_i      (push_word),
		.pop_i       (pop),
		.head_o      (head_word),
		.not_empty_o (not_empty),
		.credit_o    (credit)
	);

	st_addr_decode u_st_addr_decode (
		.cpu_i      (cpu_i),
		.mem_size_i (mem_size_i),
		.tos192k_i  (tos192k),
		.ram_en_o   (ram_en),
		.rom_addr_o (rom_addr_o)
	);

	ram_port_mux u_ram_port_mux (
		.clk_32        (clk_32),
		.xsint         (xsint),
		.cpu_i         (cpu_i),
		.ram_en_i      (ram_en),
		.upload_busy_i (upload_busy),
		.head_i        (head_word),
		.not_empty_i   (not_empty),
		.pop_o         (pop),
		.sdram_o       (sdram_o)
	);

endmodule

// File: tests/tb_clock_gen.sv
/* testbench clock and reset */

module tb_clock_gen (
	output logic clk_32,
	output logic xsint
);

	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	initial begin
		clk_32 = 1'b0;
		forever #4 clk_32 = ~clk_32;
	end

	// reset low for 8 clocks, released on a falling edge
	initial begin
		xsint = 1'b0;
		repeat (8) @(posedge clk_32);
		@(negedge clk_32);
		xsint = 1'b1;
	end

endmodule

// File: tests/tb_st_mem_checker.sv
/* sdram request checker */

`include "st_mem_defs.svh"

module tb_st_mem_checker (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  logic [71:0]            rec_i,
	input  logic                   rec_stb_i,
	input  logic                   done_i,
	input  logic                   pop_i,
	input  st_mem_pkg::sdram_req_t sdram_i,
	input  st_mem_pkg::st_addr_u   rom_addr_i,
	input  logic                   overrun_i,
	output int                     errors_o
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [15:0] exp_data [$];
	logic [22:0] exp_addr;
	logic        in_upload;
	logic        in_burst;
	logic        cpu_wait;
	logic [71:0] cpu_rec;
	longint      cyc;
	longint      last_pop;
	longint      last_wr;
	int          n_writes;
	int          n_tests;
	int          n_bad;
	int          errs_base;

	initial begin
		errors_o  = 0;
		in_upload = 1'b0;
		in_burst  = 1'b0;
		cpu_wait  = 1'b0;
		last_pop  = -100;
		last_wr   = -100;
		n_writes  = 0;
		n_tests   = 0;
		n_bad     = 0;
		errs_base = 0;
	end

	task automatic report_error(input string msg);
		$display("ERR %0t ns: %s", $time, msg);
		errors_o++;
	endtask

	// one result line per finished test
	task automatic close_test(input string name);
		n_tests++;
		if (errors_o != errs_base)
			n_bad++;
		$display("test %0d %s: %s", n_tests, name, (errors_o == errs_base) ? "ok" : "failed");
		errs_base = errors_o;
	endtask

	// first word address per upload index
	function automatic logic [22:0] upload_base(input logic [3:0] idx);
		logic [23:0] b;
		case (idx)
			4'd0: b = `UPLOAD_BASE_TOS256;
			4'd1: b = `UPLOAD_BASE_TOS192;
			4'd2: b = `UPLOAD_BASE_CART;
			default: b = `UPLOAD_BASE_CLEAR;
		endcase
		return b[23:1];
	endfunction

	////////////////////
	// upload writes
	////////////////////

	task automatic check_upload_write();
		logic [15:0] d;
		if (!(sdram_i.we & sdram_i.uds & sdram_i.lds))
			report_error("upload write without we and both lanes");
		if (sdram_i.addr.word != exp_addr)
			report_error($sformatf("upload address %h, expected %h",
				{sdram_i.addr.word, 1'b0}, {exp_addr, 1'b0}));
		exp_addr++;
		if (exp_data.size() > 0) begin
			d = exp_data.pop_front();
			if (sdram_i.wdata != d)
				report_error($sformatf("upload data %h, expected %h", sdram_i.wdata, d));
		end else if (!in_burst) begin
			report_error("upload write with no word sent");
		end
		// due on the first clock of the cpu slot 4 clocks after the pop
		if (cyc != last_pop + 4 || cyc % 16 != 4)
			report_error($sformatf("upload write %0d clocks after pop", cyc - last_pop));
		if (n_writes > 0 && cyc - last_wr < 16)
			report_error($sformatf("upload writes %0d clocks apart", cyc - last_wr));
		last_wr = cyc;
		n_writes++;
	endtask

	task automatic finish_upload();
		if (exp_data.size() != 0) begin
			$display("upload ended with %0d words never written to SDRAM", exp_data.size());
			errors_o++;
		end
		// only the burst runs out of credits
		if (overrun_i !== in_burst)
			report_error($sformatf("overrun flag %b, expected %b", overrun_i, in_burst));
		close_test(in_burst ? "upload burst" : "upload paced");
		in_upload = 1'b0;
		in_burst  = 1'b0;
	endtask

	////////////////////
	// cpu and rom
	////////////////////

	// direction and lanes follow the size column of the record
	task automatic check_cpu_request();
		logic exp_we;
		logic exp_uds;
		logic exp_lds;
		exp_we  = ~cpu_rec[64];
		exp_uds = ~cpu_rec[65];
		exp_lds = cpu_rec[65] | cpu_rec[64];
		if (sdram_i.req && !cpu_rec[0]) begin
			report_error($sformatf("request for out of range address %h", cpu_rec[63:40]));
		end else if (!sdram_i.req && cpu_rec[0]) begin
			$display("missing SDRAM request for in range address %h", cpu_rec[63:40]);
			errors_o++;
		end else if (sdram_i.req && ({sdram_i.addr.word, 1'b0} != cpu_rec[63:40] ||
				sdram_i.wdata != cpu_rec[39:24] || sdram_i.we != exp_we ||
				sdram_i.uds != exp_uds || sdram_i.lds != exp_lds)) begin
			report_error("CPU request fields differ from the access");
		end
		close_test("cpu range");
	endtask

	task automatic take_record(input logic [71:0] r);
		logic [15:0] d;
		int          k;
		case (r[71:68])
			4'h1: begin
				in_upload = 1'b1;
				in_burst  = 1'b0;
				exp_addr  = upload_base(r[67:64]);
				n_writes  = 0;
				exp_data.delete();
			end
			4'h2: exp_data.push_back({r[31:24], r[39:32]});
			4'h3: finish_upload();
			4'h4: begin
				in_burst = 1'b1;
				// first strobes always have credit
				for (k = 0; k < `UPLOAD_FIFO_DEPTH && k < int'(r[67:64]); k++) begin
					d = r[39:24] + 16'(k);
					exp_data.push_back({d[7:0], d[15:8]});
				end
			end
			4'h5: begin
				cpu_wait = 1'b1;
				cpu_rec  = r;
			end
			4'h6: begin
				if ({rom_addr_i.word, 1'b0} != r[23:0])
					report_error($sformatf("ROM address %h, expected %h",
						{rom_addr_i.word, 1'b0}, r[23:0]));
				close_test("rom remap");
			end
			default: ;
		endcase
	endtask

	// cyc 0 is the first clock of the precycle slot
	always @(posedge clk_32) begin
		if (!xsint) begin
			cyc = 0;
		end else begin
			if (pop_i) begin
				if (cyc % 16 != 0)
					report_error($sformatf("pop in schedule clock %0d", cyc % 16));
				last_pop = cyc;
			end
			if (in_upload && sdram_i.req)
				check_upload_write();
			else if (cpu_wait)
				check_cpu_request();
			else if (sdram_i.req)
				report_error("SDRAM request with no access pending");
			cpu_wait = 1'b0;
			if (rec_stb_i)
				take_record(rec_i);
			if (done_i)
				$display("%0d tests, %0d failed, %0d errors", n_tests, n_bad, errors_o);
			cyc++;
		end
	end

endmodule

// File: tests/tb_st_mem.sv
/* st memory path testbench */

module tb_st_mem;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_RECS = 64;

	logic                     clk_32;
	logic                     xsint;
	st_mem_pkg::host_upload_t upload;
	st_mem_pkg::cpu_bus_t     cpu;
	st_mem_pkg::mem_size_e    mem_size;
	st_mem_pkg::sdram_req_t   sdram;
	st_mem_pkg::st_addr_u     rom_addr;
	logic                     overrun;
	logic [71:0]              recs [MAX_RECS];
	logic [71:0]              rec;
	logic                     rec_stb;
	logic                     done;
	int                       errors;
	int                       nrec;
	int                       rec_idx;
	integer                   seed;

	tb_clock_gen u_clock_gen (
		.clk_32 (clk_32),
		.xsint  (xsint)
	);

	st_mem_top UUT (
		.clk_32     (clk_32),
		.xsint      (xsint),
		.upload_i   (upload),
		.cpu_i      (cpu),
		.mem_size_i (mem_size),
		.sdram_o    (sdram),
		.rom_addr_o (rom_addr),
		.overrun_o  (overrun)
	);

	tb_st_mem_checker u_checker (
		.clk_32     (clk_32),
		.xsint      (xsint),
		.rec_i      (rec),
		.rec_stb_i  (rec_stb),
		.done_i     (done),
		.pop_i      (UUT.pop),
		.sdram_i    (sdram),
		.rom_addr_i (rom_addr),
		.overrun_i  (overrun),
		.errors_o   (errors)
	);

	////////////////////
	// record driver
	////////////////////

	// op, arg, byte address, data, expected
	task automatic apply_record(input logic [71:0] r);
		logic [3:0]  op;
		logic [15:0] data;
		int          gap;
		int          k;
		op   = r[71:68];
		data = r[39:24];
		@(posedge clk_32);
		rec     <= r;
		// end of upload is announced once the path is idle
		rec_stb <= (op != 4'h3);
		case (op)
			4'h1: begin
				upload.download <= 1'b1;
				upload.index    <= r[67:64];
			end
			4'h2, 4'h4: begin
				upload.wr   <= 1'b1;
				upload.data <= data;
			end
			4'h3: upload.download <= 1'b0;
			4'h5: begin
				mem_size      <= st_mem_pkg::mem_size_e'(r[66:64]);
				cpu.addr.word <= r[63:41];
				cpu.wdata     <= data;
				// direction and lanes vary with the size column
				cpu.we        <= ~r[64];
				cpu.uds       <= ~r[65];
				cpu.lds       <= r[65] | r[64];
				cpu.ras_n     <= 1'b0;
			end
			4'h6: begin
				cpu.addr.word <= r[63:41];
				cpu.rom2_n    <= 1'b0;
			end
			default: ;
		endcase
		// back to back strobes
		if (op == 4'h4) begin
			for (k = 1; k < int'(r[67:64]); k++) begin
				@(posedge clk_32);
				rec_stb     <= 1'b0;
				upload.data <= data + 16'(k);
			end
		end
		@(posedge clk_32);
		rec_stb    <= 1'b0;
		upload.wr  <= 1'b0;
		cpu.rom2_n <= 1'b1;
		case (op)
			4'h2: begin
				gap = 16 + ({$random(seed)} % 9);
				repeat (gap - 1) @(posedge clk_32);
			end
			4'h3: begin
				while (UUT.upload_busy)
					@(posedge clk_32);
				// last write trails the final pop by 4 clocks
				repeat (8) @(posedge clk_32);
				rec_stb <= 1'b1;
				@(posedge clk_32);
				rec_stb <= 1'b0;
			end
			4'h5: begin
				repeat (3) @(posedge clk_32);
				cpu.ras_n <= 1'b1;
				repeat (2) @(posedge clk_32);
			end
			default: repeat (3) @(posedge clk_32);
		endcase
	endtask

	initial begin
		seed       = 32'hd0c3_c661;
		upload     = '0;
		cpu        = '0;
		cpu.ras_n  = 1'b1;
		cpu.rom2_n = 1'b1;
		mem_size   = st_mem_pkg::MEM14M;
		rec        = '0;
		rec_stb    = 1'b0;
		done       = 1'b0;
		nrec       = 0;
		$readmemh("tests/st_mem_patterns.mem", recs);
		while (nrec < MAX_RECS && !$isunknown(recs[nrec]))
			nrec++;
		if (nrec == 0) begin
			$display("no records read from tests/st_mem_patterns.mem");
			$display("** FAIL **");
			$finish;
		end else begin
			wait (xsint);
			for (rec_idx = 0; rec_idx < nrec; rec_idx++)
				apply_record(recs[rec_idx]);
			@(posedge clk_32);
			done <= 1'b1;
			@(posedge clk_32);
			done <= 1'b0;
			// error count is settled between clock edges
			@(negedge clk_32);
			if (errors == 0)
				$display("** PASS **");
			else
				$display("** FAIL **");
			$finish;
		end
	end

	// 64 clocks per record plus margin
	initial begin
		wait (nrec > 0);
		repeat (nrec * 64 + 200) @(posedge clk_32);
		$display("watchdog expired after %0d clocks, run did not finish", nrec * 64 + 200);
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: sim.f
+incdir+rtl
rtl/st_mem_pkg.sv
rtl/upload_sequencer.sv
rtl/upload_fifo.sv
rtl/st_addr_decode.sv
rtl/ram_port_mux.sv
rtl/st_mem_top.sv
tests/tb_clock_gen.sv
tests/tb_st_mem_checker.sv
tests/tb_st_mem.sv

// File: tests/st_mem_patterns.mem
// columns op arg addr data expect, 1 1 6 4 6 hex digits, addr and expect are byte addresses
// op 1 start (arg index) 2 word 3 end 4 burst (arg n) 5 cpu (arg size, expect 1 in range) 6 rom
60FD24680000E12468
110000000000000000
200000001234000000
20000000ABCD000000
300000000000000000
60FD24680000FD2468
100000000000000000
200000005A0F000000
300000000000000000
60000A100000E00A10
120000000000000000
200000000102000000
300000000000000000
130000000000000000
200000008001000000
300000000000000000
130000000000000000
470000001000000000
300000000000000000
5007FFFEC0DE000001
50080000C0DE000000
510FFFFEC0DE000001
51100000C0DE000000
521FFFFEC0DE000001
52200000C0DE000000
533FFFFEC0DE000001
53000000C0DE000000
547FFFFEC0DE000001
54800000C0DE000000
55DFFFFEC0DE000001
55E00000C0DE000000
